/* Makefile */
# Verilator build and run for mini_core

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= mini_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/alu.sv */
////////////////////
// ALU
// Kept RV32I operations on rs1 and rs2 or the immediate
////////////////////

`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire core_pkg::alu_op_e op,       // Operation
    input  wire core_pkg::word_t   a,        // rs1 data
    input  wire core_pkg::word_t   b,        // rs2 data
    input  wire                    use_imm,  // Take imm instead of b
    input  wire core_pkg::word_t   imm,      // Immediate
    output core_pkg::word_t        result    // Result
);

    core_pkg::word_t op_b;                   // Second operand
    logic [4:0]      shamt;                  // Shift amount

    assign op_b  = use_imm ? imm : b;
    assign shamt = op_b[4:0];                // Low 5 bits only

    always_comb begin
        case (op)
            core_pkg::alu_add:    result = a + op_b;
            core_pkg::alu_sub:    result = a - op_b;
            core_pkg::alu_and:    result = a & op_b;
            core_pkg::alu_or:     result = a | op_b;
            core_pkg::alu_xor:    result = a ^ op_b;
            core_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(op_b)};
            core_pkg::alu_sll:    result = a << shamt;
            core_pkg::alu_srl:    result = a >> shamt;  // Logical
            core_pkg::alu_pass_b: result = op_b;        // lui
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/branch_cmp.sv */
////////////////////
// Branch comparator
// Branch condition and pc-relative target
////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
    input  wire core_pkg::cmp_op_e op,       // Condition
    input  wire core_pkg::word_t   a,        // rs1 data
    input  wire core_pkg::word_t   b,        // rs2 data
    input  wire core_pkg::addr_t   pc,       // Instruction address
    input  wire core_pkg::word_t   imm,      // B or J offset
    output logic                   taken,    // Condition holds
    output core_pkg::addr_t        target    // Branch or jump target
);

    always_comb begin
        case (op)
            core_pkg::cmp_eq: taken = (a == b);
            core_pkg::cmp_ne: taken = (a != b);
            core_pkg::cmp_lt: taken = ($signed(a) <  $signed(b));
            core_pkg::cmp_ge: taken = ($signed(a) >= $signed(b));
            default:          taken = 1'b0;  // Not a branch
        endcase
    end

    assign target = pc + imm;                // Shared by branches and jal

endmodule

`default_nettype wire

/* hdl/commit_unit.sv */
////////////////////
// Commit unit
// Write-back value and enable, next PC selection
////////////////////

`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input  wire core_pkg::wb_sel_e  wb_sel,     // Write-back source
    input  wire                     is_jal,     // Jump
    input  wire core_pkg::reg_idx_t rd,         // Destination
    input  wire core_pkg::word_t    alu_result, // From ALU
    input  wire                     taken,      // From comparator
    input  wire core_pkg::addr_t    target,     // Branch or jump target
    input  wire core_pkg::addr_t    pc,         // Instruction address
    input  wire                     exec,       // Execute cycle
    output logic                    we,         // GPR write enable
    output core_pkg::word_t         wb_data,    // GPR write data
    output core_pkg::addr_t         next_pc     // PC for next fetch
);

    core_pkg::addr_t link;                   // Return address

    assign link = pc + core_pkg::pc_step;

    // Only in the execute cycle, never to x0
    assign we = exec && (rd != '0) && (wb_sel != core_pkg::wb_none);

    assign wb_data = (wb_sel == core_pkg::wb_link) ? link : alu_result;

    // Redirect on jal or a taken branch
    assign next_pc = (is_jal || taken) ? target : link;

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
////////////////////
// mini_core shared definitions
// Widths, data types, decode enums and the fetch state encoding
////////////////////

`default_nettype none

package core_pkg;

    ////////////////////
    // Widths and constants
    localparam int unsigned xlen = 32;                  // Data path width

    typedef logic [xlen-1:0] word_t;                    // Data word
    typedef logic [xlen-1:0] addr_t;                    // Byte address
    typedef logic [4:0]      reg_idx_t;                 // GPR index
    typedef logic [31:0]     insn_t;                    // Raw instruction

    localparam addr_t reset_pc = 32'h0000_0000;         // Reset vector
    localparam addr_t pc_step  = 32'd4;                 // Sequential step

    ////////////////////
    // Instruction classes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,                         // R-type ALU
        op_imm    = 7'b0010011,                         // I-type ALU
        op_lui    = 7'b0110111,                         // Upper immediate
        op_branch = 7'b1100011,                         // Conditional branch
        op_jal    = 7'b1101111                          // Jump and link
    } opcode_e;

    // ALU operations, pass_b forwards the second operand
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_none, cmp_eq, cmp_ne, cmp_lt, cmp_ge         // lt/ge are signed
    } cmp_op_e;

    typedef enum logic [1:0] {
        wb_alu, wb_link, wb_none                        // Write-back source
    } wb_sel_e;

    typedef enum logic {
        st_fetch, st_execute                            // One insn in flight
    } fetch_state_e;

endpackage

`default_nettype wire

/* hdl/decoder.sv */
////////////////////
// Instruction decoder
// Register indices, immediates and operation selects for the
// RV32I subset; anything else retires as a no-op
////////////////////

`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire core_pkg::insn_t insn,       // Instruction word
    output core_pkg::reg_idx_t   rs1,        // Source 1
    output core_pkg::reg_idx_t   rs2,        // Source 2
    output core_pkg::reg_idx_t   rd,         // Destination
    output core_pkg::word_t      imm,        // Sign-extended immediate
    output logic                 use_imm,    // ALU takes imm as operand b
    output core_pkg::alu_op_e    alu_op,     // ALU operation
    output core_pkg::cmp_op_e    cmp_op,     // Branch condition
    output core_pkg::wb_sel_e    wb_sel,     // Write-back source
    output logic                 is_jal      // Unconditional jump
);

    core_pkg::opcode_e opcode;               // Instruction class
    logic [2:0]        funct3;
    core_pkg::word_t   imm_i, imm_u, imm_b, imm_j;

    assign opcode = core_pkg::opcode_e'(insn[6:0]);
    assign funct3 = insn[14:12];
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];
    assign rd     = insn[11:7];

    ////////////////////
    // Immediate formats
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_u = {insn[31:12], 12'h000};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

    ////////////////////
    // Operation selects
    always_comb begin
        imm     = imm_i;
        use_imm = 1'b0;
        alu_op  = core_pkg::alu_add;
        cmp_op  = core_pkg::cmp_none;
        wb_sel  = core_pkg::wb_none;         // Default is a no-op
        is_jal  = 1'b0;
        case (opcode)
            core_pkg::op_reg, core_pkg::op_imm: begin
                use_imm = (opcode == core_pkg::op_imm);
                wb_sel  = core_pkg::wb_alu;
                case (funct3)
                    3'b000: begin
                        // Only the register form has sub
                        if (opcode == core_pkg::op_reg && insn[30]) begin
                            alu_op = core_pkg::alu_sub;
                        end else begin
                            alu_op = core_pkg::alu_add;
                        end
                    end
                    3'b001:  alu_op = core_pkg::alu_sll;
                    3'b010:  alu_op = core_pkg::alu_slt;
                    3'b100:  alu_op = core_pkg::alu_xor;
                    3'b101:  alu_op = core_pkg::alu_srl;
                    3'b110:  alu_op = core_pkg::alu_or;
                    3'b111:  alu_op = core_pkg::alu_and;
                    default: wb_sel = core_pkg::wb_none; // sltu not kept
                endcase
            end
            core_pkg::op_lui: begin
                imm     = imm_u;
                use_imm = 1'b1;
                alu_op  = core_pkg::alu_pass_b;  // rd = U immediate
                wb_sel  = core_pkg::wb_alu;
            end
            core_pkg::op_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  cmp_op = core_pkg::cmp_eq;
                    3'b001:  cmp_op = core_pkg::cmp_ne;
                    3'b100:  cmp_op = core_pkg::cmp_lt;
                    3'b101:  cmp_op = core_pkg::cmp_ge;
                    default: cmp_op = core_pkg::cmp_none; // Unsigned forms dropped
                endcase
            end
            core_pkg::op_jal: begin
                imm    = imm_j;
                wb_sel = core_pkg::wb_link;      // rd = pc + 4
                is_jal = 1'b1;
            end
            default: ;                           // Unknown, no-op
        endcase
    end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
////////////////////
// Fetch unit
// PC, instruction register and Wishbone classic fetch master.
// Alternates between a bus fetch and a single execute cycle.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                  clk,        // Clock
    input  wire                  arst_n,     // Async reset, active low
    // Wishbone classic master
    output logic                 wb_cyc,     // Bus cycle
    output logic                 wb_stb,     // Strobe
    output logic                 wb_we,      // Always read
    output core_pkg::addr_t      wb_adr,     // Fetch address
    input  wire core_pkg::insn_t wb_dat_i,   // Read data
    input  wire                  wb_ack,     // Slave ack
    // Core side
    input  wire core_pkg::addr_t next_pc,    // From commit unit
    output core_pkg::addr_t      pc,         // Current PC
    output core_pkg::insn_t      insn,       // Held instruction
    output logic                 exec        // Execute cycle flag
);

    core_pkg::fetch_state_e state;           // Fetch or execute
    core_pkg::addr_t        pc_q;            // Program counter
    logic                   cyc_q;           // Bus request

    ////////////////////
    // State machine and PC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= core_pkg::st_fetch;
            pc_q  <= core_pkg::reset_pc;
            cyc_q <= 1'b0;                   // Bus idle in reset
        end else begin
            case (state)
                core_pkg::st_fetch: begin
                    if (cyc_q && wb_ack) begin
                        cyc_q <= 1'b0;       // Drop request after ack
                        state <= core_pkg::st_execute;
                    end else begin
                        cyc_q <= 1'b1;       // Start or hold request
                    end
                end
                core_pkg::st_execute: begin
                    pc_q  <= next_pc;        // Branch, jump or step
                    cyc_q <= 1'b1;           // Next fetch right away
                    state <= core_pkg::st_fetch;
                end
            endcase
        end
    end

    // Capture the word on the ack edge
    always_ff @(posedge clk) begin
        if (state == core_pkg::st_fetch && cyc_q && wb_ack) begin
            insn <= wb_dat_i;
        end
    end

    ////////////////////
    // Outputs
    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;                   // Strobe follows cycle
    assign wb_we  = 1'b0;                    // Instruction side is read only
    assign wb_adr = pc_q;                    // Stable for whole request
    assign pc     = pc_q;
    assign exec   = (state == core_pkg::st_execute);

endmodule

`default_nettype wire

/* hdl/mini_core_top.sv */
////////////////////
// mini_core top
// Single-issue RV32I subset core, Wishbone classic instruction fetch,
// register writes exposed on the retire ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mini_core_top (
    input  wire                     clk,          // Clock
    input  wire                     arst_n,       // Async reset, active low
    // Wishbone classic fetch master
    output wire                     wb_cyc,
    output wire                     wb_stb,
    output wire                     wb_we,
    output wire core_pkg::addr_t    wb_adr,
    input  wire core_pkg::insn_t    wb_dat_i,
    input  wire                     wb_ack,
    // Retire report
    output wire                     retire_valid, // One cycle per insn
    output wire                     retire_we,    // Register written
    output wire core_pkg::reg_idx_t retire_rd,    // Written index
    output wire core_pkg::word_t    retire_data,  // Written value
    output wire core_pkg::addr_t    retire_pc     // Insn address
);

    ////////////////////
    // Internal wires
    wire core_pkg::insn_t    insn;            // Held instruction
    wire core_pkg::addr_t    next_pc;         // From commit unit
    wire core_pkg::reg_idx_t rs1, rs2;        // Source indices
    wire core_pkg::word_t    imm;             // Decoded immediate
    wire                     use_imm;
    wire core_pkg::alu_op_e  alu_op;
    wire core_pkg::cmp_op_e  cmp_op;
    wire core_pkg::wb_sel_e  wb_sel;
    wire                     is_jal;
    wire core_pkg::word_t    rs1_data, rs2_data;
    wire core_pkg::word_t    alu_result;
    wire                     cmp_taken;
    wire core_pkg::addr_t    target;          // pc + imm

    fetch_unit fetch_unit_i (
        .clk      (clk),        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),     .wb_stb   (wb_stb),
        .wb_we    (wb_we),      .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),   .wb_ack   (wb_ack),
        .next_pc  (next_pc),    .pc       (retire_pc),
        .insn     (insn),       .exec     (retire_valid)
    );

    decoder decoder_i (
        .insn     (insn),       .rs1      (rs1),
        .rs2      (rs2),        .rd       (retire_rd),
        .imm      (imm),        .use_imm  (use_imm),
        .alu_op   (alu_op),     .cmp_op   (cmp_op),
        .wb_sel   (wb_sel),     .is_jal   (is_jal)
    );

    reg_file reg_file_i (
        .clk      (clk),        .arst_n   (arst_n),
        .rs1      (rs1),        .rs2      (rs2),
        .rs1_data (rs1_data),   .rs2_data (rs2_data),
        .we       (retire_we),  .rd       (retire_rd),
        .rd_data  (retire_data)               // Write-back path
    );

    // ALU and comparator side by side on the same operands
    alu alu_i (
        .op       (alu_op),     .a        (rs1_data),
        .b        (rs2_data),   .use_imm  (use_imm),
        .imm      (imm),        .result   (alu_result)
    );

    branch_cmp branch_cmp_i (
        .op       (cmp_op),     .a        (rs1_data),
        .b        (rs2_data),   .pc       (retire_pc),
        .imm      (imm),        .taken    (cmp_taken),
        .target   (target)
    );

    commit_unit commit_unit_i (
        .wb_sel     (wb_sel),     .is_jal   (is_jal),
        .rd         (retire_rd),  .alu_result (alu_result),
        .taken      (cmp_taken),  .target   (target),
        .pc         (retire_pc),  .exec     (retire_valid),
        .we         (retire_we),  .wb_data  (retire_data),
        .next_pc    (next_pc)
    );

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
////////////////////
// General purpose registers
// 32 x 32 bits, two async read ports, one write port, x0 fixed at zero
////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                     clk,      // Clock
    input  wire                     arst_n,   // Async reset, active low
    input  wire core_pkg::reg_idx_t rs1,      // Read index 1
    input  wire core_pkg::reg_idx_t rs2,      // Read index 2
    output core_pkg::word_t         rs1_data, // Read data 1
    output core_pkg::word_t         rs2_data, // Read data 2
    input  wire                     we,       // Write enable
    input  wire core_pkg::reg_idx_t rd,       // Write index
    input  wire core_pkg::word_t    rd_data   // Write data
);

    core_pkg::word_t regs [32];              // Register array

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;               // All cleared
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;             // x0 never written
        end
    end

    // Unclocked reads, x0 reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* mini_core.f */
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_cmp.sv
hdl/commit_unit.sv
hdl/mini_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mini_core.sv

/* testbench/mini_core_patterns.txt */
# M addr word = slave memory, F addr = next expected fetch, R rd value = next expected write
# Addresses and values in hex, rd in decimal, text after # is ignored
M 00000000 00500093  F 00000000  R 1  00000005  # addi x1, x0, 5
M 00000004 FFD00113  F 00000004  R 2  FFFFFFFD  # addi x2, x0, -3
M 00000008 00708013  F 00000008                 # addi x0, x1, 7 (no write)
M 0000000C 002081B3  F 0000000C  R 3  00000002  # add  x3, x1, x2
M 00000010 40208233  F 00000010  R 4  00000008  # sub  x4, x1, x2
M 00000014 0020F2B3  F 00000014  R 5  00000005  # and  x5, x1, x2
M 00000018 00016333  F 00000018  R 6  FFFFFFFD  # or   x6, x2, x0
M 0000001C 0020C3B3  F 0000001C  R 7  FFFFFFF8  # xor  x7, x1, x2
M 00000020 00112433  F 00000020  R 8  00000001  # slt  x8, x2, x1
M 00000024 001094B3  F 00000024  R 9  000000A0  # sll  x9, x1, x1
M 00000028 00115533  F 00000028  R 10 07FFFFFF  # srl  x10, x2, x1
M 0000002C 123455B7  F 0000002C  R 11 12345000  # lui  x11, 0x12345
M 00000030 6785E613  F 00000030  R 12 12345678  # ori  x12, x11, 0x678
M 00000034 FFF0C693  F 00000034  R 13 FFFFFFFA  # xori x13, x1, -1
M 00000038 00012713  F 00000038  R 14 00000001  # slti x14, x2, 0
M 0000003C 00309793  F 0000003C  R 15 00000028  # slli x15, x1, 3
M 00000040 01C15813  F 00000040  R 16 0000000F  # srli x16, x2, 28
M 00000044 07F17893  F 00000044  R 17 0000007D  # andi x17, x2, 0x7f
M 00000048 00208463  F 00000048                 # beq x1, x2, +8 not taken
M 0000004C 00108463  F 0000004C                 # beq x1, x1, +8 taken
M 00000054 00109463  F 00000054                 # bne x1, x1, +8 not taken
M 00000058 00209463  F 00000058                 # bne x1, x2, +8 taken
M 00000060 0020C463  F 00000060                 # blt x1, x2, +8 not taken
M 00000064 00114463  F 00000064                 # blt x2, x1, +8 taken
M 0000006C 00115463  F 0000006C                 # bge x2, x1, +8 not taken
M 00000070 0020D463  F 00000070                 # bge x1, x2, +8 taken
M 00000078 00C00A6F  F 00000078  R 20 0000007C  # jal x20, +12
M 00000084 0000006F  F 00000084  F 00000084     # jal x0, 0 loops here

/* testbench/tb_clock_gen.sv */
////////////////////
// Testbench clock and reset
// Free-running clock and an arst_n held low for a number of cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 4,          // Clock period
    parameter int reset_cycles = 16          // Cycles in reset
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        arst_n <= 1'b0;                      // Reset from time 0
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;                      // Release on a rising edge
    end

endmodule

`default_nettype wire

/* testbench/tb_mini_core.sv */
////////////////////
// mini_core testbench
// Wishbone fetch slave with random ack delay, checks of the fetch
// order and the register writes against the pattern file
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mini_core;

    localparam int    clk_period_ns   = 4;
    localparam int    reset_cycles    = 16;
    localparam int    max_ack_delay   = 3;             // Slave wait states
    localparam int    watchdog_margin = 2;
    localparam int    seed_init       = 32'h6787;
    localparam string pattern_file    = "testbench/mini_core_patterns.txt";

    logic               clk, arst_n;
    logic               wb_cyc, wb_stb, wb_we, wb_ack;
    core_pkg::addr_t    wb_adr;
    core_pkg::insn_t    wb_dat_i;
    logic               retire_valid, retire_we;
    core_pkg::reg_idx_t retire_rd;
    core_pkg::word_t    retire_data;
    core_pkg::addr_t    retire_pc;

    core_pkg::insn_t    mem [core_pkg::addr_t];         // Slave memory
    core_pkg::addr_t    fetch_q [$];                    // Expected fetch order
    core_pkg::reg_idx_t rd_q [$];                       // Expected write index
    core_pkg::word_t    data_q [$];                     // Expected write value
    core_pkg::addr_t    fetch_adr;                      // Address of open request
    logic               in_fetch;                       // Request seen, no ack yet
    logic               retire_due;                     // Ack given, retire next
    logic               loaded;
    int                 delay;                          // Wait states left
    int                 seed;
    int                 watchdog_ns;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(reset_cycles)) clock_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mini_core_top dut_i (
        .clk          (clk),          .arst_n      (arst_n),
        .wb_cyc       (wb_cyc),       .wb_stb      (wb_stb),
        .wb_we        (wb_we),        .wb_adr      (wb_adr),
        .wb_dat_i     (wb_dat_i),     .wb_ack      (wb_ack),
        .retire_valid (retire_valid), .retire_we   (retire_we),
        .retire_rd    (retire_rd),    .retire_data (retire_data),
        .retire_pc    (retire_pc)
    );

    ////////////////////
    // Failure handling
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t ns  %s: actual %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    ////////////////////
    // Pattern file reader
    task automatic load_patterns();
        int                 fd;
        int                 n;
        logic [7:0]         kind;                       // Record letter
        string              rest;
        core_pkg::addr_t    adr;
        core_pkg::insn_t    word;
        core_pkg::reg_idx_t rd;
        core_pkg::word_t    value;
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            abort_run({"Cannot open pattern file ", pattern_file});
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": n = $fgets(rest, fd);         // Comment up to end of line
                    "M": begin
                        n = $fscanf(fd, "%h %h", adr, word);
                        mem[adr] = word;
                    end
                    "F": begin
                        n = $fscanf(fd, "%h", adr);
                        fetch_q.push_back(adr);
                    end
                    "R": begin
                        n = $fscanf(fd, "%d %h", rd, value);
                        rd_q.push_back(rd);
                        data_q.push_back(value);
                    end
                    default: abort_run("Unknown record kind in pattern file");
                endcase
            end
            $fclose(fd);
        end
    endtask

    // Unloaded addresses return an address-derived word
    function automatic core_pkg::insn_t read_word(input core_pkg::addr_t adr);
        if (mem.exists(adr)) begin
            return mem[adr];
        end else begin
            return adr ^ 32'hC0DE_F00D;
        end
    endfunction

    // New request checked against the expected fetch order
    task automatic open_fetch();
        core_pkg::addr_t expected_adr;
        if (fetch_q.size() == 0) begin
            abort_run($sformatf("Fetch from %h after the last expected fetch", wb_adr));
        end else begin
            expected_adr = fetch_q.pop_front();
            check("wb_adr", wb_adr, expected_adr);
            fetch_adr = expected_adr;
            in_fetch  = 1'b1;
            delay     = $unsigned($random(seed)) % (max_ack_delay + 1);
        end
    endtask

    ////////////////////
    // Wishbone slave
    always @(posedge clk) begin
        check("wb_we", 32'(wb_we), 32'd0);             // Fetch side never writes
        if (!arst_n) begin
            check("wb_cyc", 32'(wb_cyc), 32'd0);
            check("wb_stb", 32'(wb_stb), 32'd0);
            check("retire_valid", 32'(retire_valid), 32'd0);
            wb_ack     <= 1'b0;
            in_fetch   = 1'b0;
            retire_due = 1'b0;
        end else begin
            // One execute cycle after each ack with the bus idle
            check("retire_valid", 32'(retire_valid), 32'(retire_due));
            if (retire_due) begin
                check("retire_pc", retire_pc, fetch_adr);
                check("wb_cyc", 32'(wb_cyc), 32'd0);
            end
            retire_due = 1'b0;
            if (wb_ack) begin
                wb_ack     <= 1'b0;                    // One-cycle ack
                in_fetch   = 1'b0;
                retire_due = 1'b1;
            end else if (wb_cyc && wb_stb) begin
                if (!in_fetch) begin
                    open_fetch();
                end else begin
                    check("wb_adr", wb_adr, fetch_adr); // Held until ack
                end
                if (delay == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= read_word(wb_adr);
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

    ////////////////////
    // Retire checks
    always @(posedge clk) begin : retire_check
        core_pkg::reg_idx_t exp_rd;
        core_pkg::word_t    exp_data;
        if (arst_n && retire_we) begin
            if (!retire_valid) begin
                abort_run("retire_we was high outside a retire cycle");
            end else if (rd_q.size() == 0) begin
                abort_run($sformatf("Write to x%0d after the last expected write",
                                    retire_rd));
            end else begin
                exp_rd   = rd_q.pop_front();
                exp_data = data_q.pop_front();
                check("retire_rd", 32'(retire_rd), 32'(exp_rd));
                check("retire_data", retire_data, exp_data);
            end
        end
    end

    ////////////////////
    // Run control
    initial begin
        wb_ack     <= 1'b0;                            // Slave idle at start
        wb_dat_i   <= '0;
        in_fetch   = 1'b0;
        retire_due = 1'b0;
        delay      = 0;
        seed       = seed_init;
        loaded     = 1'b0;
        load_patterns();
        watchdog_ns = (reset_cycles + fetch_q.size() * (max_ack_delay + 2))
                      * clk_period_ns * watchdog_margin;
        loaded = 1'b1;
        while (fetch_q.size() != 0 || rd_q.size() != 0) begin
            @(posedge clk);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #(watchdog_ns);
        abort_run($sformatf("Timeout after %0d ns with %0d fetches and %0d writes missing",
                            watchdog_ns, fetch_q.size(), rd_q.size()));
    end

endmodule

`default_nettype wire
